//--- verilog.f
common/ppuPkg.sv
verilog/scanTiming.sv
verilog/cpuRegs.sv
background/bgFetch.sv
background/pixelOut.sv
verilog/ppuTop.sv
tb/ppuTb.sv

//--- Makefile
# Verilator build and run of the picture processor testbench

VERILATOR ?= verilator
TOP       ?= ppuTb
FILELIST  ?= verilog.f
OBJDIR    ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing
FAILMSG   ?= Done: errors found
PASSMSG   ?= Done: no errors

SOURCES := $(shell cat $(FILELIST))
EXE     := $(OBJDIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(EXE)

$(EXE): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)

run: $(EXE)
	./$(EXE) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "$(FAILMSG)" $(LOG); then echo "FAIL: see $(LOG)"; exit 1; fi
	@grep -q "$(PASSMSG)" $(LOG) || { echo "FAIL: run ended early, see $(LOG)"; exit 1; }
	@echo "PASS"

clean:
	rm -rf $(OBJDIR) $(LOG)

//--- tb/ppuTb.sv
// Self-checking testbench for ppuTop; models both memories, drives the CPU bus and checks every pin
`timescale 1ns/1ps

module ppuTb;

    localparam int LineCycles  = int'(ppuPkg::HWhole);
    localparam int FrameLines  = int'(ppuPkg::VWhole);
    localparam int FrameCycles = LineCycles * FrameLines;
    localparam int TimeoutCycles = 3 * FrameCycles + 1000;   // Setup frame plus two checked frames
    localparam int HsStart = int'(ppuPkg::HVisible) + int'(ppuPkg::HFront);
    localparam int VsStart = int'(ppuPkg::VVisible) + int'(ppuPkg::VFront);
    localparam int Left    = int'(ppuPkg::BorderLeft);
    localparam int Right   = int'(ppuPkg::BorderRight);
    localparam ppuPkg::cpuBusT BusIdle = '0;

    logic              CLK25;
    logic              RESET;
    ppuPkg::cpuBusT    bus;
    logic [7:0]        DOUT;
    logic [10:0]       VADDR;
    logic [7:0]        VDATA;
    logic [12:0]       FADDR;
    logic [7:0]        FDATA;
    ppuPkg::vramWriteT vramWr;
    logic              NMI;
    logic              HS;
    logic              VS;
    logic [4:0]        RED;
    logic [5:0]        GREEN;
    logic [4:0]        BLUE;

    int          scanX;          // Beam in the current cycle
    int          scanY;
    int          prevX;          // Beam one cycle back, owner of the pins
    int          prevY;
    int          cycles = 0;
    int          picCount = 0;
    int          errorCount = 0;
    logic        picCheckOn;
    logic        expBgEn;        // Expected renderer controls
    logic        expShowLeft;
    logic        expNtBank;
    logic        expPatSel;
    logic [5:0]  palShadow [16];   // Palette as written by the test
    logic [21:0] vramSeen [$];     // Captured VRAM writes, {addr, data}
    integer      seed;

    ppuTop dut0 (
        .CLK25(CLK25), .RESET(RESET), .bus(bus), .DOUT(DOUT), .VADDR(VADDR), .VDATA(VDATA),
        .FADDR(FADDR), .FDATA(FDATA), .vramWr(vramWr), .NMI(NMI), .HS(HS), .VS(VS),
        .RED(RED), .GREEN(GREEN), .BLUE(BLUE)
    );

    // ------------------------------
    // Memory models, read combinationally
    function automatic logic [7:0] vramByte(input logic [10:0] addr);
        if (addr[9:6] == 4'b1111) return 8'hE4;   // Attribute area
        return addr[7:0];                          // Tile number is the low address byte
    endfunction

    function automatic logic [7:0] patternByte(input logic [12:0] addr);
        return addr[7:0] ^ 8'h5A;
    endfunction

    assign VDATA = vramByte(VADDR);
    assign FDATA = patternByte(FADDR);

    // Expected RGB of one screen position
    function automatic ppuPkg::rgbT expectedPixel(input int px, input int py);
        logic [7:0] col;
        logic [7:0] row;
        logic [7:0] tile;
        logic [7:0] attr;
        logic [7:0] lo;
        logic [7:0] hi;
        logic [7:0] shifted;
        logic [2:0] bitSel;
        logic [3:0] idx;
        if (px >= int'(ppuPkg::HVisible) || py >= int'(ppuPkg::VVisible)) return '0;
        idx = 4'h0;                  // Backdrop
        col = 8'((px - Left) / 2);   // Picture column, 2 clocks per dot
        row = 8'(py / 2);
        if (px >= Left && px < Right && expBgEn && (expShowLeft || px >= Left + 16)) begin
            tile    = vramByte({expNtBank, row[7:3], col[7:3]});
            attr    = vramByte({expNtBank, 4'b1111, row[7:5], col[7:5]});
            lo      = patternByte({expPatSel, tile, 1'b0, row[2:0]});
            hi      = patternByte({expPatSel, tile, 1'b1, row[2:0]});
            bitSel  = 3'd7 - col[2:0];                 // Leftmost dot is bit 7
            shifted = attr >> {row[4], col[4], 1'b0};  // Quadrant pair
            if (lo[bitSel] || hi[bitSel]) idx = {shifted[1:0], hi[bitSel], lo[bitSel]};
        end
        return ppuPkg::colourToRgb(palShadow[idx]);
    endfunction

    task automatic checkValue(input string name, input logic [31:0] expected,
                              input logic [31:0] actual);
        if (expected !== actual) begin
            errorCount++;
            $display("** Error %s: expected %0h, actual %0h", name, expected, actual);
            $display("Done: errors found");
            $fatal(1, "stopped at first mismatch");
        end
    endtask

    // ------------------------------
    // Bus access, one-cycle strobes launched on the falling edge
    task automatic writeReg(input logic [2:0] sel, input logic [7:0] data);
        @(negedge CLK25);
        bus = '{sel: sel, data: data, rd: 1'b0, wr: 1'b1};
        @(negedge CLK25);
        bus = BusIdle;
    endtask

    task automatic readReg(input logic [2:0] sel, output logic [7:0] data);
        @(negedge CLK25);
        bus = '{sel: sel, data: 8'h00, rd: 1'b1, wr: 1'b0};
        @(negedge CLK25);
        bus  = BusIdle;
        data = DOUT;   // Loaded on the edge in between
    endtask

    task automatic setAddr(input logic [13:0] addr);
        writeReg(ppuPkg::RegAddr, {2'b00, addr[13:8]});   // High byte first
        writeReg(ppuPkg::RegAddr, addr[7:0]);
    endtask

    task automatic checkPalette(input string name);
        logic [7:0] value;
        setAddr(ppuPkg::PaletteBase);
        for (int n = 0; n < 16; n++) begin
            readReg(ppuPkg::RegData, value);
            checkValue($sformatf("%s entry %0d", name, n), 32'(palShadow[n]), 32'(value));
        end
    endtask

    task automatic waitPos(input int x, input int y);
        @(negedge CLK25);
        while (scanX != x || scanY != y) @(negedge CLK25);
    endtask

    // ------------------------------
    initial begin
        CLK25 = 1'b0;
        forever #5 CLK25 = ~CLK25;   // 100 MHz sim clock stands in for 25 MHz
    end

    // Beam model from the VGA timing
    always @(posedge CLK25) begin
        if (RESET) begin
            scanX <= 0;
            scanY <= 0;
        end else begin
            prevX <= scanX;
            prevY <= scanY;
            if (scanX == LineCycles - 1) begin
                scanX <= 0;
                scanY <= (scanY == FrameLines - 1) ? 0 : scanY + 1;
            end else begin
                scanX <= scanX + 1;
            end
        end
    end

    // Pins during this cycle belong to the previous position
    always @(negedge CLK25) begin
        if (picCheckOn) begin
            checkValue($sformatf("pixel %0d,%0d", prevX, prevY),
                       32'(expectedPixel(prevX, prevY)), 32'({RED, GREEN, BLUE}));
            picCount++;
        end
    end

    always @(negedge CLK25) begin
        if (vramWr.we) vramSeen.push_back({vramWr.addr, vramWr.data});
    end

    always @(posedge CLK25) begin
        cycles <= cycles + 1;
        if (cycles > TimeoutCycles) begin
            $display("Timeout: run did not finish within %0d cycles", TimeoutCycles);
            $display("Done: errors found");
            $fatal(1, "timeout");
        end
    end

    // ------------------------------
    initial begin
        logic [31:0] rnd;
        logic [7:0]  value;
        logic [13:0] base;
        logic [21:0] expVram [$];
        int          hsCount;
        int          vsCount;
        logic        expHs;
        logic        expVs;
        logic        expNmi;
        seed        = 32'hd800d2a1;
        bus         = BusIdle;
        RESET       = 1'b1;
        picCheckOn  <= 1'b0;
        expBgEn     = 1'b0;
        expShowLeft = 1'b0;
        expNtBank   = 1'b0;
        expPatSel   = 1'b0;
        hsCount     = 0;
        vsCount     = 0;
        repeat (5) @(negedge CLK25);
        RESET = 1'b0;

        // Palette write and read back
        readReg(ppuPkg::RegStatus, value);   // Restart the address pair
        setAddr(ppuPkg::PaletteBase);
        for (int n = 0; n < 16; n++) begin
            rnd = $random(seed);
            palShadow[n] = rnd[5:0];
            writeReg(ppuPkg::RegData, rnd[7:0]);
        end
        checkPalette("palette");
        writeReg(ppuPkg::RegCtrl0, 8'h04);   // Step 32, second write leaves the palette
        setAddr(ppuPkg::PaletteBase + 14'd5);
        for (int n = 0; n < 2; n++) begin
            rnd = $random(seed);
            if (n == 0) palShadow[5] = rnd[5:0];
            writeReg(ppuPkg::RegData, rnd[7:0]);
        end
        writeReg(ppuPkg::RegCtrl0, 8'h00);   // Step 1 again for the read back
        checkPalette("palette step 32");
        checkValue("palette VRAM writes", 0, 32'(vramSeen.size()));

        // VRAM writes with step 1, then step 32
        for (int k = 0; k < 2; k++) begin
            base = k ? 14'h2123 : 14'h2045;
            writeReg(ppuPkg::RegCtrl0, k ? 8'h04 : 8'h00);
            setAddr(base);
            for (int j = 0; j < 3; j++) begin
                rnd = $random(seed);
                writeReg(ppuPkg::RegData, rnd[7:0]);
                expVram.push_back({base + 14'(k ? 32 * j : j), rnd[7:0]});
            end
        end
        repeat (2) @(negedge CLK25);
        checkValue("VRAM write count", 32'(expVram.size()), 32'(vramSeen.size()));
        foreach (expVram[n]) checkValue("VRAM write", 32'(expVram[n]), 32'(vramSeen[n]));

        // VBlank flag with NMI masked
        writeReg(ppuPkg::RegCtrl1, 8'h08);   // Background on, left column hidden
        writeReg(ppuPkg::RegCtrl0, 8'h11);
        expBgEn   = 1'b1;
        expNtBank = 1'b1;
        expPatSel = 1'b1;
        waitPos(1, 482);
        checkValue("NMI masked", 0, 32'(NMI));
        waitPos(0, 483);
        readReg(ppuPkg::RegStatus, value);
        checkValue("status set", 32'h80, 32'(value));
        readReg(ppuPkg::RegStatus, value);
        checkValue("status cleared", 0, 32'(value));
        writeReg(ppuPkg::RegCtrl0, 8'h91);   // NMI enable on
        checkValue("NMI after read", 0, 32'(NMI));

        // Two frames: picture, then background off from line 500 on
        waitPos(0, 0);
        picCheckOn <= 1'b1;
        for (int n = 0; n < 2 * FrameCycles; n++) begin
            @(negedge CLK25);
            expHs  = (scanX >= HsStart) && (scanX < HsStart + int'(ppuPkg::HSync));
            expVs  = (scanY >= VsStart) && (scanY < VsStart + int'(ppuPkg::VSync));
            expNmi = (scanY > 482 && scanY < 522) || (scanY == 482 && scanX > 0) ||
                     (scanY == 522 && scanX == 0);
            checkValue("HS", 32'(expHs), 32'(HS));
            checkValue("VS", 32'(expVs), 32'(VS));
            checkValue("NMI", 32'(expNmi), 32'(NMI));
            if (HS) hsCount++;
            if (VS) vsCount++;
            if (n < FrameCycles && scanX == 0 && scanY == 500) begin
                bus = '{sel: ppuPkg::RegCtrl1, data: 8'h02, rd: 1'b0, wr: 1'b1};
                expBgEn     = 1'b0;
                expShowLeft = 1'b1;
            end else begin
                bus = BusIdle;
            end
        end
        picCheckOn <= 1'b0;
        @(negedge CLK25);
        checkValue("HS cycles", 32'(2 * FrameLines * int'(ppuPkg::HSync)), 32'(hsCount));
        checkValue("VS cycles", 32'(2 * LineCycles * int'(ppuPkg::VSync)), 32'(vsCount));
        checkValue("pixels compared", 32'(2 * FrameCycles), 32'(picCount));

        if (errorCount == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

//--- verilog/ppuTop.sv
// Background picture processor top; joins timing, CPU registers, fetcher and pixel output
`timescale 1ns/1ps

module ppuTop (
    input  logic              CLK25,
    input  logic              RESET,
    input  ppuPkg::cpuBusT    bus,       // CPU register access
    output logic [7:0]        DOUT,
    output logic [10:0]       VADDR,     // Name table memory
    input  logic [7:0]        VDATA,
    output logic [12:0]       FADDR,     // Pattern memory
    input  logic [7:0]        FDATA,
    output ppuPkg::vramWriteT vramWr,
    output logic              NMI,
    output logic              HS,
    output logic              VS,
    output logic [4:0]        RED,
    output logic [5:0]        GREEN,
    output logic [4:0]        BLUE
);

    ppuPkg::scanPosT pos;
    ppuPkg::ppuCtrlT ctrl;
    logic            dotEn;
    logic [8:0]      picRow;
    logic            vblankSet;
    logic            vblankClr;
    logic [3:0]      palIndex;
    logic [5:0]      palColour;
    logic [3:0]      pixIndex;

    // ------------------------------
    scanTiming u0 (
        .CLK25(CLK25), .RESET(RESET), .pos(pos), .dotEn(dotEn), .picRow(picRow),
        .vblankSet(vblankSet), .vblankClr(vblankClr), .HS(HS), .VS(VS)
    );

    cpuRegs u1 (
        .CLK25(CLK25), .RESET(RESET), .bus(bus), .vblankSet(vblankSet),
        .vblankClr(vblankClr), .ctrl(ctrl), .palIndex(palIndex), .palColour(palColour),
        .DOUT(DOUT), .vramWr(vramWr), .NMI(NMI)
    );

    bgFetch u2 (
        .CLK25(CLK25), .RESET(RESET), .pos(pos), .dotEn(dotEn), .picRow(picRow),
        .ctrl(ctrl), .VADDR(VADDR), .VDATA(VDATA), .FADDR(FADDR), .FDATA(FDATA),
        .pixIndex(pixIndex)
    );

    pixelOut u3 (
        .CLK25(CLK25), .RESET(RESET), .pos(pos), .ctrl(ctrl), .pixIndex(pixIndex),
        .palIndex(palIndex), .palColour(palColour), .RED(RED), .GREEN(GREEN), .BLUE(BLUE)
    );

endmodule

//--- background/pixelOut.sv
// Pixel output stage; masks the window edges, looks up the palette and registers RGB565
`timescale 1ns/1ps

module pixelOut (
    input  logic            CLK25,
    input  logic            RESET,
    input  ppuPkg::scanPosT pos,
    input  ppuPkg::ppuCtrlT ctrl,
    input  logic [3:0]      pixIndex,
    output logic [3:0]      palIndex,    // Background palette entry
    input  logic [5:0]      palColour,
    output logic [4:0]      RED,
    output logic [5:0]      GREEN,
    output logic [4:0]      BLUE
);

    // Hidden left column is 8 picture dots wide
    localparam logic [9:0] HideEnd = ppuPkg::BorderLeft + 10'd16;

    logic        inWindow;
    logic        hidden;
    ppuPkg::rgbT pixel;

    // ------------------------------
    // Palette index, entry 0 is the backdrop
    assign inWindow = (pos.x >= ppuPkg::BorderLeft) && (pos.x < ppuPkg::BorderRight);
    assign hidden   = !ctrl.bgEn ||
                      (!ctrl.showLeft && (pos.x < HideEnd));   // CTRL1 bit 1 clear

    assign palIndex = (inWindow && !hidden) ? pixIndex : 4'h0;

    // ------------------------------
    // One clock to the pins
    always_ff @(posedge CLK25) begin
        if (RESET) begin
            pixel <= '0;
        end else if (pos.visible) begin
            pixel <= ppuPkg::colourToRgb(palColour);
        end else begin
            pixel <= '0;   // Blanking
        end
    end

    assign RED   = pixel.red;
    assign GREEN = pixel.green;
    assign BLUE  = pixel.blue;

endmodule

//--- background/bgFetch.sv
// Background tile fetcher; reads name, attribute and pattern bytes and shifts out colour indices
`timescale 1ns/1ps

module bgFetch (
    input  logic            CLK25,
    input  logic            RESET,
    input  ppuPkg::scanPosT pos,
    input  logic            dotEn,
    input  logic [8:0]      picRow,
    input  ppuPkg::ppuCtrlT ctrl,
    output logic [10:0]     VADDR,      // Name table memory
    input  logic [7:0]      VDATA,
    output logic [12:0]     FADDR,      // Pattern memory
    input  logic [7:0]      FDATA,
    output logic [3:0]      pixIndex    // Attribute bits and plane bits
);

    // Fetch column 0 starts 16 clocks before the window
    localparam logic [9:0] FetchStart = ppuPkg::BorderLeft - 10'd16;

    logic [9:0] fetchOffset;
    logic [7:0] fetchCol;    // Picture column being fetched
    logic [2:0] step;        // Dot within the tile
    logic [7:0] tileRow;
    logic [7:0] patLo;
    logic [7:0] patHi;
    logic [7:0] attrByte;
    logic [1:0] attrNext;    // Quadrant bits of the fetched tile
    logic [7:0] dispLo;      // Tile on screen
    logic [7:0] dispHi;
    logic [1:0] dispAttr;
    logic [9:0] xNext;
    logic [2:0] dispBit;
    logic       planeLo;
    logic       planeHi;

    assign fetchOffset = pos.x - FetchStart;
    assign fetchCol    = fetchOffset[8:1];
    assign step        = fetchCol[2:0];
    assign tileRow     = picRow[7:0];

    assign attrNext = {attrByte[{tileRow[4], fetchCol[4], 1'b1}],
                       attrByte[{tileRow[4], fetchCol[4], 1'b0}]};

    // ------------------------------
    // Memory reads, one tile ahead of the beam
    always_ff @(posedge CLK25) begin
        if (dotEn) begin
            case (step)
                3'd0: VADDR <= {ctrl.ntBank, tileRow[7:3], fetchCol[7:3]};   // 32x30 tiles
                3'd1: begin
                    FADDR <= {ctrl.patSel, VDATA, 1'b0, tileRow[2:0]};   // Low plane
                    VADDR <= {ctrl.ntBank, 4'b1111, tileRow[7:5], fetchCol[7:5]};
                end
                3'd2: begin
                    FADDR[3] <= 1'b1;   // High plane next
                    patLo    <= FDATA;
                    attrByte <= VDATA;
                end
                3'd3: patHi <= FDATA;
                default: ;
            endcase
        end
    end

    // ------------------------------
    // Pixel selection is made one clock early and registered
    assign xNext   = pos.x + 10'd1;
    assign dispBit = ~xNext[3:1];   // Leftmost pixel is bit 7
    assign planeLo = dispLo[dispBit];
    assign planeHi = dispHi[dispBit];

    always_ff @(posedge CLK25) begin
        if (RESET) begin
            dispLo   <= '0;
            dispHi   <= '0;
            dispAttr <= '0;
            pixIndex <= '0;
        end else begin
            if (dotEn && (step == 3'd7)) begin
                dispLo   <= patLo;   // Swap in the fetched tile at the boundary
                dispHi   <= patHi;
                dispAttr <= attrNext;
            end
            // Both planes clear is the backdrop
            pixIndex <= (planeHi || planeLo) ? {dispAttr, planeHi, planeLo} : 4'h0;
        end
    end

endmodule

//--- verilog/cpuRegs.sv
// CPU register window of the picture processor; holds control, VRAM address, palette and VBlank
`timescale 1ns/1ps

module cpuRegs (
    input  logic              CLK25,
    input  logic              RESET,
    input  ppuPkg::cpuBusT    bus,
    input  logic              vblankSet,
    input  logic              vblankClr,
    output ppuPkg::ppuCtrlT   ctrl,
    input  logic [3:0]        palIndex,    // Renderer palette lookup
    output logic [5:0]        palColour,
    output logic [7:0]        DOUT,
    output ppuPkg::vramWriteT vramWr,
    output logic              NMI
);

    logic [5:0]  palette [16];   // Background palette, 3F00..3F0F
    logic [13:0] vramAddr;       // Data register address
    logic        incBy32;        // CTRL0 bit 2
    logic        secondWrite;    // Next address write is the low byte
    logic        vblank;
    logic [13:0] wrAddr;
    logic [7:0]  wrData;
    logic        wrPulse;
    logic        dataWrite;
    logic        dataAccess;
    logic        statusRead;
    logic        inPalette;
    logic        belowPalette;

    assign dataWrite    = bus.wr && (bus.sel == ppuPkg::RegData);
    assign dataAccess   = (bus.rd || bus.wr) && (bus.sel == ppuPkg::RegData);
    assign statusRead   = bus.rd && (bus.sel == ppuPkg::RegStatus);
    assign inPalette    = (vramAddr[13:4] == ppuPkg::PaletteBase[13:4]);
    assign belowPalette = (vramAddr < ppuPkg::PaletteBase);

    // ------------------------------
    // Control registers, only the bits the renderer uses
    always_ff @(posedge CLK25) begin
        if (RESET) begin
            ctrl    <= '0;
            incBy32 <= 1'b0;
        end else if (bus.wr) begin
            case (bus.sel)
                ppuPkg::RegCtrl0: begin
                    ctrl.ntBank <= bus.data[0];   // Name table select, bit 1 ignored
                    incBy32     <= bus.data[2];
                    ctrl.patSel <= bus.data[4];
                    ctrl.nmiEn  <= bus.data[7];
                end
                ppuPkg::RegCtrl1: begin
                    ctrl.showLeft <= bus.data[1];
                    ctrl.bgEn     <= bus.data[3];
                end
                default: ;
            endcase
        end
    end

    // ------------------------------
    // Two-write address register and post-access increment
    always_ff @(posedge CLK25) begin
        if (RESET) begin
            secondWrite <= 1'b0;
            vramAddr    <= '0;
        end else begin
            if (statusRead) begin
                secondWrite <= 1'b0;   // Status read restarts the pair
            end else if (bus.wr && (bus.sel == ppuPkg::RegAddr)) begin
                if (secondWrite) begin
                    vramAddr[7:0] <= bus.data;
                end else begin
                    vramAddr[13:8] <= bus.data[5:0];   // High byte first
                end
                secondWrite <= !secondWrite;
            end else if (dataAccess) begin
                vramAddr <= vramAddr + (incBy32 ? 14'd32 : 14'd1);
            end
        end
    end

    // Palette storage
    always_ff @(posedge CLK25) begin
        if (dataWrite && inPalette) begin
            palette[vramAddr[3:0]] <= bus.data[5:0];
        end
    end

    assign palColour = palette[palIndex];

    // VRAM write goes out one cycle after the data write
    always_ff @(posedge CLK25) begin
        if (dataWrite) begin
            wrAddr <= vramAddr;
            wrData <= bus.data;
        end
    end

    always_ff @(posedge CLK25) begin
        if (RESET) wrPulse <= 1'b0;
        else       wrPulse <= dataWrite && belowPalette;
    end

    assign vramWr = '{addr: wrAddr, data: wrData, we: wrPulse};

    // ------------------------------
    // Read data, held until the next read
    always_ff @(posedge CLK25) begin
        if (RESET) begin
            DOUT <= 8'h00;
        end else if (bus.rd) begin
            case (bus.sel)
                ppuPkg::RegStatus: DOUT <= {vblank, 7'd0};
                ppuPkg::RegData:   DOUT <= inPalette ? {2'b00, palette[vramAddr[3:0]]} : 8'h00;
                default:           DOUT <= 8'h00;   // Write-only registers
            endcase
        end
    end

    // VBlank flag; the row event wins over a status read in the same cycle
    always_ff @(posedge CLK25) begin
        if (RESET)                         vblank <= 1'b0;
        else if (vblankSet)                vblank <= 1'b1;
        else if (vblankClr || statusRead)  vblank <= 1'b0;
    end

    assign NMI = vblank && ctrl.nmiEn;

endmodule

//--- verilog/scanTiming.sv
// VGA raster counters; gives sync, beam position, the dot step enable and VBlank row events
`timescale 1ns/1ps

module scanTiming (
    input  logic            CLK25,
    input  logic            RESET,
    output ppuPkg::scanPosT pos,         // Beam position and visible flag
    output logic            dotEn,       // Picture dot step, every second clock
    output logic [8:0]      picRow,      // Picture line, two VGA lines each
    output logic            vblankSet,   // VBlank start, one cycle
    output logic            vblankClr,   // VBlank end, one cycle
    output logic            HS,
    output logic            VS
);

    // Dot steps run 8 picture dots (16 clocks) ahead of the window
    localparam logic [9:0] FetchStart = ppuPkg::BorderLeft - 10'd16;
    localparam logic [9:0] FetchEnd   = ppuPkg::BorderRight - 10'd16;

    logic [9:0] x;
    logic [9:0] y;
    logic       lineEnd;
    logic       frameEnd;
    logic       visible;

    assign lineEnd  = (x == ppuPkg::HWhole - 10'd1);
    assign frameEnd = (y == ppuPkg::VWhole - 10'd1);

    // ------------------------------
    // Raster counters
    always_ff @(posedge CLK25) begin
        if (RESET) begin
            x <= '0;
            y <= '0;
        end else begin
            x <= lineEnd ? 10'd0 : x + 10'd1;   // 0..799
            if (lineEnd) begin
                y <= frameEnd ? 10'd0 : y + 10'd1;   // 0..524
            end
        end
    end

    // ------------------------------
    // Sync pulses, positive polarity
    assign HS = (x >= ppuPkg::HVisible + ppuPkg::HFront) &&
                (x <  ppuPkg::HVisible + ppuPkg::HFront + ppuPkg::HSync);
    assign VS = (y >= ppuPkg::VVisible + ppuPkg::VFront) &&
                (y <  ppuPkg::VVisible + ppuPkg::VFront + ppuPkg::VSync);

    assign visible = (x < ppuPkg::HVisible) && (y < ppuPkg::VVisible);
    assign pos     = '{x: x, y: y, visible: visible};

    // Half rate dot steps, only where the fetcher works
    assign dotEn  = !x[0] && (x >= FetchStart) && (x < FetchEnd);
    assign picRow = y[9:1];

    // First clock of the even VGA line of each event row
    assign vblankSet = (x == 10'd0) && (y == {ppuPkg::VBlankSetRow, 1'b0});   // y = 482
    assign vblankClr = (x == 10'd0) && (y == {ppuPkg::VBlankClrRow, 1'b0});   // y = 522

endmodule

//--- common/ppuPkg.sv
// Shared constants, bus structs and colour table; every block refers to them as ppuPkg::name
package ppuPkg;

    // VGA timing -------------------------
    localparam logic [9:0] HVisible = 10'd640;   // Visible columns
    localparam logic [9:0] HFront   = 10'd16;
    localparam logic [9:0] HSync    = 10'd96;
    localparam logic [9:0] HWhole   = 10'd800;   // Clocks per line
    localparam logic [9:0] VVisible = 10'd480;
    localparam logic [9:0] VFront   = 10'd10;
    localparam logic [9:0] VSync    = 10'd2;
    localparam logic [9:0] VWhole   = 10'd525;   // Lines per frame

    // Picture window in VGA columns, 256 dots at 2 clocks each
    localparam logic [9:0] BorderLeft  = 10'd64;
    localparam logic [9:0] BorderRight = 10'd576;

    // Picture rows that open and close VBlank
    localparam logic [8:0] VBlankSetRow = 9'd241;
    localparam logic [8:0] VBlankClrRow = 9'd261;

    // CPU register window ----------------
    localparam logic [2:0]  RegCtrl0    = 3'd0;
    localparam logic [2:0]  RegCtrl1    = 3'd1;
    localparam logic [2:0]  RegStatus   = 3'd2;
    localparam logic [2:0]  RegAddr     = 3'd6;
    localparam logic [2:0]  RegData     = 3'd7;
    localparam logic [13:0] PaletteBase = 14'h3F00;   // Palette space starts here

    typedef struct packed {
        logic [2:0] sel;    // Register select
        logic [7:0] data;   // Write data
        logic       rd;     // Read strobe, one cycle
        logic       wr;     // Write strobe, one cycle
    } cpuBusT;

    typedef struct packed {
        logic [13:0] addr;
        logic [7:0]  data;
        logic        we;
    } vramWriteT;

    typedef struct packed {
        logic ntBank;     // CTRL0 bit 0
        logic patSel;     // CTRL0 bit 4, background pattern table
        logic bgEn;       // CTRL1 bit 3
        logic showLeft;   // CTRL1 bit 1
        logic nmiEn;      // CTRL0 bit 7
    } ppuCtrlT;

    typedef struct packed {
        logic [4:0] red;
        logic [5:0] green;
        logic [4:0] blue;
    } rgbT;

    typedef struct packed {
        logic [9:0] x;
        logic [9:0] y;
        logic       visible;   // Inside 640x480
    } scanPosT;

    // ------------------------------
    // Colour number to raw 16-bit value, blue in the top bits
    localparam logic [0:63][15:0] ColourTable = {
        16'h73ae, 16'h88c4, 16'ha800, 16'h9808, 16'h7011, 16'h1015, 16'h0014, 16'h004f,
        16'h0168, 16'h0220, 16'h0280, 16'h11e0, 16'h59e3, 16'h0000, 16'h0000, 16'h0000,
        16'hbdf7, 16'heb80, 16'he9c4, 16'hf010, 16'hb817, 16'h581c, 16'h015b, 16'h0a79,
        16'h0391, 16'h04a0, 16'h0540, 16'h3c80, 16'h8c00, 16'h0000, 16'h0000, 16'h0000,
        16'hffff, 16'hfde7, 16'hfcab, 16'hfc54, 16'hfbde, 16'hb3bf, 16'h63bf, 16'h3cdf,
        16'h3dfe, 16'h1690, 16'h4ee9, 16'h9fcb, 16'hdf40, 16'h0000, 16'h0000, 16'h0000,
        16'hffff, 16'hff35, 16'hfeb8, 16'hfe5a, 16'hfe3f, 16'hde3f, 16'hb5ff, 16'haedf,
        16'ha73f, 16'ha7fc, 16'hbf95, 16'hcff6, 16'hf7f3, 16'h0000, 16'h0000, 16'h0000
    };

    // Red sits in the low bits of the table value, so the fields are swapped here
    function automatic rgbT colourToRgb(input logic [5:0] colour);
        logic [15:0] raw;
        raw = ColourTable[colour];
        colourToRgb = '{red: raw[4:0], green: raw[10:5], blue: raw[15:11]};
    endfunction

endpackage
